/* Bender.yml */
package:
  name: sysrow

sources:
  # Design sources in compile order
  - files:
      - rtl/sysrow_pkg.sv
      - rtl/sysrow_ce.sv
      - rtl/sysrow_skew.sv
      - rtl/sysrow_row.sv
      - rtl/sysrow_ctrl.sv
      - rtl/sysrow_top.sv
  # Testbench sources
  - target: simulation
    files:
      - bench/sysrow_clkgen.sv
      - bench/sysrow_checker.sv
      - bench/sysrow_tb.sv

/* bench/sysrow_checker.sv */
// *******************
// Handshake checker
// Concurrent assertions on the systolic row top-level ports
// *******************

`timescale 1ns/1ns

module sysrow_checker (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         out_ready_i,
  input logic                         flush_i,
  input logic                         in_ready_i,
  input logic                         out_valid_i,
  input logic                         busy_i,
  input logic [sysrow_pkg::ACC_W-1:0] z_i
);

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // No result may be offered while in reset
  reset_quiet : assert property (@(posedge clk_i) !rst_ni |-> !out_valid_i)
    else begin
      $error("Output valid is high during reset");
      fail_cnt++;
    end

  // A waiting result stays put until the consumer takes it
  output_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i && $stable(z_i)))
    else begin
      $error("Held result changed or vanished before it was taken");
      fail_cnt++;
    end

  ready_rule : assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_i == (!out_valid_i || out_ready_i))
    else begin
      $error("Input ready does not follow the output handshake");
      fail_cnt++;
    end

  // Flush empties every stage in one edge
  flush_empties : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !busy_i)
    else begin
      $error("Row still busy one cycle after flush");
      fail_cnt++;
    end

endmodule : sysrow_checker

/* bench/sysrow_clkgen.sv */
// *******************
// Testbench clock source
// Free-running clock with a 4 ns period
// *******************

`timescale 1ns/1ns

module sysrow_clkgen (
  output logic clk_o
);

  localparam int unsigned PERIOD_NS = 4;

  initial begin : clock_source
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule : sysrow_clkgen

/* bench/sysrow_tb.sv */
// *******************
// Systolic row testbench
// Random and directed items against a reference dot product,
// with back-pressure, flush and a watchdog
// *******************

`timescale 1ns/1ns

module sysrow_tb;

  import sysrow_pkg::*;

  localparam int unsigned CLK_NS       = 4;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned STREAM_ITEMS = 200;
  localparam int unsigned RANDOM_ITEMS = 300;
  localparam int unsigned FLUSH_ITEMS  = 12;
  localparam int unsigned TOTAL_ITEMS  = 1 + STREAM_ITEMS + RANDOM_ITEMS + 2 + FLUSH_ITEMS + 2;
  // Gaps, ready drops and drains cost far less than this per item
  localparam int unsigned STALL_FACTOR = 10;
  localparam int unsigned LIMIT_NS     = (TOTAL_ITEMS * STALL_FACTOR + ROW_LAT) * CLK_NS;

  logic                         clk;
  logic                         rst_n;
  logic                         in_valid;
  logic                         in_ready;
  logic                         out_valid;
  logic                         out_ready;
  logic                         flush;
  logic                         busy;
  logic [ROW_H-1:0][DATA_W-1:0] x_lanes;
  logic [ROW_H-1:0][DATA_W-1:0] w_lanes;
  logic [ACC_W-1:0]             bias;
  logic [ACC_W-1:0]             z;

  // Expected results with the cycle and stall count at acceptance
  logic [ACC_W-1:0] exp_q[$];
  int unsigned      acc_cycle_q[$];
  int unsigned      acc_stall_q[$];
  int unsigned      cycle_cnt;
  int unsigned      stall_cnt;
  int unsigned      out_cnt;
  logic             held;
  logic [ACC_W-1:0] held_z;
  logic [31:0]      rng;
  logic             ready_random;

  sysrow_clkgen i_clkgen (
    .clk_o ( clk )
  );

  sysrow_top uut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .out_ready_i ( out_ready ),
    .flush_i     ( flush     ),
    .x_i         ( x_lanes   ),
    .w_i         ( w_lanes   ),
    .bias_i      ( bias      ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .busy_o      ( busy      ),
    .z_o         ( z         )
  );

  bind sysrow_top sysrow_checker i_checker (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .out_ready_i ( out_ready_i ),
    .flush_i     ( flush_i     ),
    .in_ready_i  ( in_ready_o  ),
    .out_valid_i ( out_valid_o ),
    .busy_i      ( busy_o      ),
    .z_i         ( z_o         )
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] r;
    r = s;
    r = r ^ (r << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // Bias plus signed sum of products, wrapped to the result width
  function automatic logic [ACC_W-1:0] ref_dot(input logic [ROW_H-1:0][DATA_W-1:0] x,
                                               input logic [ROW_H-1:0][DATA_W-1:0] w,
                                               input logic [ACC_W-1:0]             b);
    longint acc;
    acc = longint'($signed(b));
    for (int i = 0; i < ROW_H; i++) begin
      acc = acc + longint'($signed(x[i])) * longint'($signed(w[i]));
    end
    return ACC_W'(acc);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Advance one clock and drive the consumer side
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (ready_random) begin
      rng       = xorshift(rng);
      out_ready = (rng[2:0] > 3'd2);
    end
  endtask

  task automatic send_item(input logic [ROW_H-1:0][DATA_W-1:0] x,
                           input logic [ROW_H-1:0][DATA_W-1:0] w,
                           input logic [ACC_W-1:0]             b);
    logic accepted;
    in_valid = 1'b1;
    x_lanes  = x;
    w_lanes  = w;
    bias     = b;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic random_item(output logic [ROW_H-1:0][DATA_W-1:0] x,
                             output logic [ROW_H-1:0][DATA_W-1:0] w,
                             output logic [ACC_W-1:0]             b);
    for (int i = 0; i < ROW_H; i++) begin
      rng  = xorshift(rng);
      x[i] = rng[15:0];
      w[i] = rng[31:16];
    end
    rng = xorshift(rng);
    b   = rng;
  endtask

  // Bubbles carry junk data that must not reach any result
  task automatic idle_cycles(input int unsigned n);
    in_valid = 1'b0;
    repeat (n) begin
      rng     = xorshift(rng);
      x_lanes = {ROW_H{rng[DATA_W-1:0]}};
      w_lanes = {ROW_H{rng[31:32-DATA_W]}};
      next_cycle();
    end
  endtask

  task automatic drain();
    ready_random = 1'b0;
    out_ready    = 1'b1;
    while (exp_q.size() != 0 || busy) begin
      next_cycle();
    end
  endtask

  always @(negedge clk) begin : compare_results
    logic [ACC_W-1:0] exp_z;
    int unsigned      exp_lat;
    int unsigned      lat;
    assert (uut.i_checker.fail_cnt == 0)
      else abort_run("A handshake assertion in the bound checker failed");
    if (rst_n !== 1'b1 || flush) begin
      exp_q.delete();
      acc_cycle_q.delete();
      acc_stall_q.delete();
      held = 1'b0;
    end else begin
      if (held) begin
        assert (out_valid)
          else abort_run("Output valid dropped before the result was taken");
        assert (z == held_z)
          else abort_run($sformatf("Fail z_o held: got 0x%08h expected 0x%08h", z, held_z));
      end
      // Every accepted item that has not left yet keeps the row busy
      assert (busy == (exp_q.size() != 0))
        else abort_run($sformatf("Fail busy_o: got 0x%0h expected 0x%0h", busy,
                                 exp_q.size() != 0));
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0)
          else abort_run("A result appeared with no item in flight");
        exp_z   = exp_q.pop_front();
        exp_lat = ROW_LAT + (stall_cnt - acc_stall_q.pop_front());
        lat     = cycle_cnt - acc_cycle_q.pop_front();
        assert (z == exp_z)
          else abort_run($sformatf("Fail z_o: got 0x%08h expected 0x%08h", z, exp_z));
        assert (lat == exp_lat)
          else abort_run($sformatf("Result took %0d cycles instead of %0d", lat, exp_lat));
        out_cnt++;
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_dot(x_lanes, w_lanes, bias));
        acc_cycle_q.push_back(cycle_cnt);
        acc_stall_q.push_back(stall_cnt);
      end
      // A frozen edge adds one cycle to everything in flight
      if (out_valid && !out_ready) begin
        stall_cnt++;
      end
      held   = out_valid && !out_ready;
      held_z = z;
    end
    cycle_cnt++;
  end

  initial begin : watchdog
    #(LIMIT_NS);
    abort_run("Timeout: the run did not finish within the expected time");
  end

  initial begin : run_tests
    logic [ROW_H-1:0][DATA_W-1:0] x;
    logic [ROW_H-1:0][DATA_W-1:0] w;
    logic [ACC_W-1:0]             b;
    int unsigned                  kept;
    rng          = 32'h8436_44d6;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    flush        = 1'b0;
    x_lanes      = '0;
    w_lanes      = '0;
    bias         = '0;
    ready_random = 1'b0;
    cycle_cnt    = 0;
    stall_cnt    = 0;
    out_cnt      = 0;
    kept         = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid && !busy && in_ready)
      else abort_run("Handshake outputs are not idle after reset");
    next_cycle();

    // Known item: 1*5 + 2*6 + 3*7 + 4*8 + 10
    x = {16'd4, 16'd3, 16'd2, 16'd1};
    w = {16'd8, 16'd7, 16'd6, 16'd5};
    b = 32'd10;
    assert (ref_dot(x, w, b) == 32'h0000_0050)
      else abort_run("Reference model disagrees with the hand-computed value");
    out_ready = 1'b1;
    send_item(x, w, b);
    kept++;
    drain();

    // Full-rate stream
    for (int i = 0; i < STREAM_ITEMS; i++) begin
      random_item(x, w, b);
      send_item(x, w, b);
      kept++;
    end
    drain();

    // Random input gaps and consumer back-pressure
    ready_random = 1'b1;
    for (int i = 0; i < RANDOM_ITEMS; i++) begin
      rng = xorshift(rng);
      idle_cycles(rng[3] ? rng[1:0] : 0);
      random_item(x, w, b);
      send_item(x, w, b);
      kept++;
    end
    drain();

    // Extreme operands that wrap the accumulator
    x = {ROW_H{16'h8000}};
    w = {ROW_H{16'h8000}};
    b = 32'h7FFF_FFFF;
    assert (ref_dot(x, w, b) == 32'h7FFF_FFFF)
      else abort_run("Reference model wraps the most negative products wrongly");
    send_item(x, w, b);
    kept++;
    x = {ROW_H{16'h7FFF}};
    b = 32'h8000_0000;
    assert (ref_dot(x, w, b) == 32'h8002_0000)
      else abort_run("Reference model wraps mixed-sign products wrongly");
    send_item(x, w, b);
    kept++;
    drain();

    // Flush with items still travelling, then with a result held
    for (int pass = 0; pass < 2; pass++) begin
      out_ready = (pass == 0);
      for (int i = 0; i < FLUSH_ITEMS / 2; i++) begin
        random_item(x, w, b);
        send_item(x, w, b);
      end
      while (pass == 1 && !out_valid) begin
        next_cycle();
      end
      flush = 1'b1;
      next_cycle();
      flush     = 1'b0;
      out_ready = 1'b1;
      @(negedge clk);
      assert (!busy && !out_valid)
        else abort_run("Items survived the flush");
      next_cycle();
      idle_cycles(ROW_LAT + 2);
      random_item(x, w, b);
      send_item(x, w, b);
      kept++;
      drain();
    end

    assert (uut.i_checker.fail_cnt == 0)
      else abort_run("A handshake assertion in the bound checker failed");
    assert (out_cnt == kept)
      else abort_run($sformatf("Got %0d results for %0d kept items", out_cnt, kept));
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : sysrow_tb

/* rtl/sysrow_ce.sv */
// *******************
// Systolic computing element
// Signed integer multiply-add of one operand pair onto the
// partial sum coming from the left, held in a stallable register
// *******************

`timescale 1ns/1ns

module sysrow_ce (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  input  logic [sysrow_pkg::DATA_W-1:0] x_i,
  input  logic [sysrow_pkg::DATA_W-1:0] w_i,
  input  logic [sysrow_pkg::ACC_W-1:0]  psum_i,
  output logic [sysrow_pkg::ACC_W-1:0]  psum_o
);

  import sysrow_pkg::*;

  // Full-precision product of the two lanes
  logic signed [2*DATA_W-1:0] prod;

  // Product brought to the accumulator width
  logic signed [ACC_W-1:0] prod_ext;

  // Multiply-add result before the register
  logic [ACC_W-1:0] sum;

  // Pipeline register of this element
  logic [ACC_W-1:0] psum_q;

  assign prod = $signed(x_i) * $signed(w_i);

  // Signed cast keeps the sign when the accumulator is wider
  assign prod_ext = ACC_W'(prod);

  // Wraps modulo 2^ACC_W
  assign sum = prod_ext + psum_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : ce_register
    if (!rst_ni) begin
      psum_q <= '0;
    end else begin
      if (flush_i) begin
        psum_q <= '0;
      end else if (en_i) begin
        psum_q <= sum;
      end
    end
  end

  assign psum_o = psum_q;

endmodule : sysrow_ce

/* rtl/sysrow_ctrl.sv */
// *******************
// Systolic row controller
// Tracks items in flight, derives the global pipeline enable
// and handles flush
// *******************

`timescale 1ns/1ns

module sysrow_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic in_valid_i,
  input  logic out_ready_i,
  input  logic flush_i,
  output logic en_o,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic busy_o
);

  import sysrow_pkg::*;

  // One valid bit per pipeline stage, bit 0 is the entry
  logic [ROW_LAT-1:0] valid_q;

  // Pipeline may advance
  logic stall_en;

  // Tail of the valid chain marks a result on z_o
  assign out_valid_o = valid_q[ROW_LAT-1];

  // Freeze only while a result waits for the consumer.
  // A bubble at the tail lets the chain move on
  assign stall_en = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_chain
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end else if (stall_en) begin
        valid_q <= {valid_q[ROW_LAT-2:0], in_valid_i};
      end
    end
  end

  // Accepting only when the chain moves means no item is lost
  assign in_ready_o = stall_en;
  assign en_o       = stall_en;

  // Any stage holding an item
  assign busy_o = |valid_q;

endmodule : sysrow_ctrl

/* rtl/sysrow_pkg.sv */
// *******************
// Systolic row package
// Shared widths, row height and the latency of the
// computing-element chain
// *******************

package sysrow_pkg;

  // Width of one activation or weight lane
  localparam int unsigned DATA_W = 16;

  // Width of bias, partial sums and the row result
  localparam int unsigned ACC_W = 32;

  // Computing elements chained in one row
  localparam int unsigned ROW_H = 4;

  // Element register plus intermediate output register
  localparam int unsigned CE_LAT = 2;

  // Full latency from accepted item to row output
  localparam int unsigned ROW_LAT = ROW_H * CE_LAT;

endpackage : sysrow_pkg

/* rtl/sysrow_row.sv */
// *******************
// Systolic dot-product row
// Chain of computing elements, each followed by an output register,
// with the bias entering at the first element
// *******************

`timescale 1ns/1ns

module sysrow_row (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 en_i,
  input  logic                                                 flush_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] x_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] w_i,
  input  logic                         [sysrow_pkg::ACC_W-1:0] bias_i,
  output logic                         [sysrow_pkg::ACC_W-1:0] z_o
);

  import sysrow_pkg::*;

  // Partial sum presented to each element
  logic [ROW_H-1:0][ACC_W-1:0] psum_in;

  // Element register outputs
  logic [ROW_H-1:0][ACC_W-1:0] partial_result;

  // Intermediate output registers between elements
  logic [ROW_H-1:0][ACC_W-1:0] output_q;

  for (genvar idx = 0; idx < ROW_H; idx++) begin : gen_element
    if (idx == 0) begin : gen_bias
      assign psum_in[idx] = bias_i;
    end else begin : gen_chain
      assign psum_in[idx] = output_q[idx-1];
    end

    sysrow_ce i_ce (
      .clk_i   ( clk_i               ),
      .rst_ni  ( rst_ni              ),
      .en_i    ( en_i                ),
      .flush_i ( flush_i             ),
      .x_i     ( x_i[idx]            ),
      .w_i     ( w_i[idx]            ),
      .psum_i  ( psum_in[idx]        ),
      .psum_o  ( partial_result[idx] )
    );

    // Second register of each hop, same stall and flush as the element
    always_ff @(posedge clk_i or negedge rst_ni) begin : output_register
      if (!rst_ni) begin
        output_q[idx] <= '0;
      end else begin
        if (flush_i) begin
          output_q[idx] <= '0;
        end else if (en_i) begin
          output_q[idx] <= partial_result[idx];
        end
      end
    end
  end

  assign z_o = output_q[ROW_H-1];

endmodule : sysrow_row

/* rtl/sysrow_skew.sv */
// *******************
// Input skew stage
// Delays lane i by i * CE_LAT enabled cycles so that activations
// and weights meet the partial sum travelling down the row
// *******************

`timescale 1ns/1ns

module sysrow_skew (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 en_i,
  input  logic                                                 flush_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] x_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] w_i,
  output logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] x_o,
  output logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] w_o
);

  import sysrow_pkg::*;

  for (genvar lane = 0; lane < ROW_H; lane++) begin : gen_lane
    if (lane == 0) begin : gen_direct
      // First element sees the item on the accepting edge
      assign x_o[lane] = x_i[lane];
      assign w_o[lane] = w_i[lane];
    end else begin : gen_delay
      localparam int unsigned DEPTH = lane * CE_LAT;

      // Stage 0 is the entry, stage DEPTH-1 feeds the row
      logic [DEPTH-1:0][DATA_W-1:0] x_sr;
      logic [DEPTH-1:0][DATA_W-1:0] w_sr;

      always_ff @(posedge clk_i or negedge rst_ni) begin : delay_line
        if (!rst_ni) begin
          x_sr <= '0;
          w_sr <= '0;
        end else begin
          if (flush_i) begin
            x_sr <= '0;
            w_sr <= '0;
          end else if (en_i) begin
            x_sr[0] <= x_i[lane];
            w_sr[0] <= w_i[lane];
            for (int s = 1; s < DEPTH; s++) begin
              x_sr[s] <= x_sr[s-1];
              w_sr[s] <= w_sr[s-1];
            end
          end
        end
      end

      assign x_o[lane] = x_sr[DEPTH-1];
      assign w_o[lane] = w_sr[DEPTH-1];
    end
  end

endmodule : sysrow_skew

/* rtl/sysrow_top.sv */
// *******************
// Systolic row top level
// Controller, input skew stage and dot-product row
// *******************

`timescale 1ns/1ns

module sysrow_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 in_valid_i,
  input  logic                                                 out_ready_i,
  input  logic                                                 flush_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] x_i,
  input  logic [sysrow_pkg::ROW_H-1:0][sysrow_pkg::DATA_W-1:0] w_i,
  input  logic                         [sysrow_pkg::ACC_W-1:0] bias_i,
  output logic                                                 in_ready_o,
  output logic                                                 out_valid_o,
  output logic                                                 busy_o,
  output logic                         [sysrow_pkg::ACC_W-1:0] z_o
);

  import sysrow_pkg::*;

  // Global advance for every pipeline register
  logic stall_en;

  // Staggered lanes into the row
  logic [ROW_H-1:0][DATA_W-1:0] x_skew;
  logic [ROW_H-1:0][DATA_W-1:0] w_skew;

  sysrow_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .in_valid_i  ( in_valid_i  ),
    .out_ready_i ( out_ready_i ),
    .flush_i     ( flush_i     ),
    .en_o        ( stall_en    ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .busy_o      ( busy_o      )
  );

  sysrow_skew i_skew (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .en_i    ( stall_en ),
    .flush_i ( flush_i  ),
    .x_i     ( x_i      ),
    .w_i     ( w_i      ),
    .x_o     ( x_skew   ),
    .w_o     ( w_skew   )
  );

  // Bias skips the skew stage, element 0 uses it on the accepting edge
  sysrow_row i_row (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .en_i    ( stall_en ),
    .flush_i ( flush_i  ),
    .x_i     ( x_skew   ),
    .w_i     ( w_skew   ),
    .bias_i  ( bias_i   ),
    .z_o     ( z_o      )
  );

endmodule : sysrow_top

/* sim.f */
rtl/sysrow_pkg.sv
rtl/sysrow_ce.sv
rtl/sysrow_skew.sv
rtl/sysrow_row.sv
rtl/sysrow_ctrl.sv
rtl/sysrow_top.sv
bench/sysrow_clkgen.sv
bench/sysrow_checker.sv
bench/sysrow_tb.sv
